//--- rtl/cache_bank_defines.svh
`ifndef CACHE_BANK_DEFINES_SVH
`define CACHE_BANK_DEFINES_SVH

// byte address and data word.
`define BANK_ADDR_W 32
`define BANK_DATA_W 32

// crossbar channel id.
`define BANK_CH_W 2

// sets per way, power of two.
`define BANK_SETS 8

`endif

//--- rtl/cache_bank_pkg.sv
`include "cache_bank_defines.svh"

package cache_bank_pkg;

  typedef enum logic {
    BANK_OP_READ  = 1'b0,
    BANK_OP_WRITE = 1'b1
  } bank_op_e;

  // operation seen by the data array.
  typedef enum logic [1:0] {
    SC_READ  = 2'd0,
    SC_WRITE = 2'd1,
    SC_FILL  = 2'd2,
    SC_SKIP  = 2'd3
  } sc_op_e;

  typedef struct packed {
    sc_op_e                         op;
    logic [`BANK_CH_W-1:0]          ch_id;
    bank_op_e                       opcode;
    logic                           hit;
    logic [$clog2(`BANK_SETS)-1:0]  set_idx;
    logic                           way;
    logic [`BANK_DATA_W-1:0]        data;   // write data or refill data.
  } htu_sc_t;

  typedef struct packed {
    logic [`BANK_CH_W-1:0]   ch_id;
    bank_op_e                opcode;
    logic                    hit;
    logic [`BANK_DATA_W-1:0] rdata;
  } bank_resp_t;

endpackage

//--- rtl/bank_skid_buf.sv
module bank_skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     main_valid_q;
  logic     skid_valid_q;
  payload_t main_q;
  payload_t skid_q;
  logic     in_fire;
  logic     main_free;
  logic     load_main;
  logic     load_skid;

  assign ready_o = !skid_valid_q;  // straight from a flop.
  assign valid_o = main_valid_q;
  assign data_o  = main_q;

  assign in_fire   = valid_i && ready_o;
  assign main_free = !main_valid_q || ready_i;
  assign load_main = main_free && (skid_valid_q || in_fire);
  assign load_skid = !main_free && in_fire;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (main_free) begin
        // skid drains first, input is blocked meanwhile.
        main_valid_q <= skid_valid_q || in_fire;
        skid_valid_q <= 1'b0;
      end else if (in_fire) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main) begin
      main_q <= skid_valid_q ? skid_q : data_i;
    end
    if (load_skid) begin
      skid_q <= data_i;
    end
  end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

//--- rtl/bank_htu.sv
`include "cache_bank_defines.svh"

module bank_htu (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_valid_i,
  output logic                     req_allow_in_o,
  input  logic [`BANK_CH_W-1:0]    req_ch_id_i,
  input  cache_bank_pkg::bank_op_e req_opcode_i,
  input  logic [`BANK_ADDR_W-1:0]  req_addr_i,
  input  logic [`BANK_DATA_W-1:0]  req_wdata_i,
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output logic                     mem_req_we_o,
  output logic [`BANK_ADDR_W-1:0]  mem_req_addr_o,
  output logic [`BANK_DATA_W-1:0]  mem_req_wdata_o,
  input  logic                     mem_rsp_valid_i,
  input  logic [`BANK_DATA_W-1:0]  mem_rsp_data_i,
  output logic                     sc_valid_o,
  input  logic                     sc_ready_i,
  output cache_bank_pkg::htu_sc_t  sc_data_o
);

  import cache_bank_pkg::*;

  localparam int SET_W = $clog2(`BANK_SETS);
  localparam int TAG_W = `BANK_ADDR_W - SET_W - 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM_WR,
    ST_REFILL
  } state_e;

  state_e                       state_q;
  state_e                       state_d;
  logic [TAG_W-1:0]             tag_q [`BANK_SETS][2];
  logic [`BANK_SETS-1:0][1:0]   valid_q;
  logic [`BANK_SETS-1:0]        lru_q;    // way to evict next.
  logic                         sent_q;
  logic                         done_q;
  logic [`BANK_CH_W-1:0]        ch_q;
  logic                         hit_q;
  logic                         way_q;
  logic [`BANK_ADDR_W-1:0]      addr_q;
  logic [`BANK_DATA_W-1:0]      data_q;
  logic [SET_W-1:0]             req_set;
  logic [TAG_W-1:0]             req_tag;
  logic [SET_W-1:0]             cur_set;
  logic [1:0]                   hit_vec;
  logic                         req_hit;
  logic                         hit_way;
  logic                         victim_way;
  logic                         req_fire;
  logic                         mem_fire;
  logic                         rsp_fire;
  logic                         push;

  assign req_set = req_addr_i[2 +: SET_W];
  assign req_tag = req_addr_i[`BANK_ADDR_W-1 -: TAG_W];
  assign cur_set = addr_q[2 +: SET_W];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hit_vec[w] = valid_q[req_set][w] && (tag_q[req_set][w] == req_tag);
    end
  end

  assign req_hit = |hit_vec;
  assign hit_way = hit_vec[1];
  // empty way first, else lru.
  assign victim_way = !valid_q[req_set][0] ? 1'b0 :
                      !valid_q[req_set][1] ? 1'b1 : lru_q[req_set];

  assign req_allow_in_o = (state_q == ST_IDLE) && sc_ready_i;
  assign req_fire = req_valid_i && req_allow_in_o;
  assign mem_fire = mem_req_valid_o && mem_req_ready_i;
  assign rsp_fire = (state_q == ST_REFILL) && mem_rsp_valid_i;

  always_comb begin
    if (state_q == ST_IDLE) begin
      // write-through goes out in the accept cycle.
      mem_req_valid_o = req_fire && (req_opcode_i == BANK_OP_WRITE);
      mem_req_we_o    = 1'b1;
      mem_req_addr_o  = req_addr_i;
      mem_req_wdata_o = req_wdata_i;
    end else begin
      mem_req_valid_o = !sent_q;
      mem_req_we_o    = (state_q == ST_MEM_WR);
      mem_req_addr_o  = addr_q;
      mem_req_wdata_o = data_q;
    end
  end

  always_comb begin
    state_d           = state_q;
    push              = 1'b0;
    sc_data_o.ch_id   = ch_q;
    sc_data_o.opcode  = BANK_OP_WRITE;
    sc_data_o.hit     = hit_q;
    sc_data_o.set_idx = cur_set;
    sc_data_o.way     = way_q;
    sc_data_o.data    = data_q;
    sc_data_o.op      = SC_SKIP;
    if (hit_q) begin
      sc_data_o.op = SC_WRITE;
    end
    case (state_q)
      ST_IDLE: begin
        sc_data_o.ch_id   = req_ch_id_i;
        sc_data_o.opcode  = req_opcode_i;
        sc_data_o.hit     = req_hit;
        sc_data_o.set_idx = req_set;
        sc_data_o.way     = hit_way;
        sc_data_o.data    = req_wdata_i;
        if (req_opcode_i == BANK_OP_READ) begin
          sc_data_o.op = SC_READ;
          push = req_fire && req_hit;
          if (req_fire && !req_hit) begin
            state_d = ST_REFILL;
          end
        end else begin
          sc_data_o.op = req_hit ? SC_WRITE : SC_SKIP;
          push = mem_fire;
          if (req_fire && !mem_fire) begin
            state_d = ST_MEM_WR;
          end
        end
      end
      ST_MEM_WR: begin
        push = (sent_q || mem_fire) && sc_ready_i;
      end
      ST_REFILL: begin
        sc_data_o.op     = SC_FILL;
        sc_data_o.opcode = BANK_OP_READ;
        sc_data_o.hit    = 1'b0;
        sc_data_o.data   = done_q ? data_q : mem_rsp_data_i;
        push = (done_q || mem_rsp_valid_i) && sc_ready_i;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
    if (push && state_q != ST_IDLE) begin
      state_d = ST_IDLE;
    end
  end

  assign sc_valid_o = push;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      sent_q  <= 1'b0;
      done_q  <= 1'b0;
      valid_q <= '0;
      lru_q   <= '0;
    end else begin
      state_q <= state_d;
      if (push) begin
        sent_q <= 1'b0;
        done_q <= 1'b0;
      end else begin
        if (mem_fire && state_q != ST_IDLE) begin
          sent_q <= 1'b1;
        end
        if (rsp_fire) begin
          done_q <= 1'b1;
        end
      end
      if (req_fire && req_hit) begin
        lru_q[req_set] <= !hit_way;
      end
      if (rsp_fire) begin
        valid_q[cur_set][way_q] <= 1'b1;
        lru_q[cur_set] <= !way_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      ch_q   <= req_ch_id_i;
      hit_q  <= req_hit;
      way_q  <= req_hit ? hit_way : victim_way;
      addr_q <= req_addr_i;
      data_q <= req_wdata_i;
    end else if (rsp_fire) begin
      data_q <= mem_rsp_data_i;   // held if downstream is full.
    end
    if (rsp_fire) begin
      tag_q[cur_set][way_q] <= addr_q[`BANK_ADDR_W-1 -: TAG_W];
    end
  end

  a_one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_fire && !mem_req_we_o |=> !mem_req_valid_o until_with mem_rsp_valid_i);

  a_single_hit: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> !(&hit_vec));

endmodule

//--- rtl/bank_sram_ctrl.sv
`include "cache_bank_defines.svh"

module bank_sram_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       sc_valid_i,
  output logic                       sc_ready_o,
  input  cache_bank_pkg::htu_sc_t    sc_data_i,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output cache_bank_pkg::bank_resp_t resp_data_o
);

  import cache_bank_pkg::*;

  logic [`BANK_DATA_W-1:0] data_q [`BANK_SETS][2];
  logic                    sc_fire;
  logic                    wr_en;

  // one op in, one response out.
  assign sc_ready_o   = resp_ready_i;
  assign resp_valid_o = sc_valid_i;

  assign sc_fire = sc_valid_i && resp_ready_i;
  assign wr_en   = sc_fire && (sc_data_i.op == SC_WRITE || sc_data_i.op == SC_FILL);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      data_q[sc_data_i.set_idx][sc_data_i.way] <= sc_data_i.data;
    end
  end

  always_comb begin
    resp_data_o.ch_id  = sc_data_i.ch_id;
    resp_data_o.opcode = sc_data_i.opcode;
    resp_data_o.hit    = sc_data_i.hit;
    case (sc_data_i.op)
      SC_READ: begin
        resp_data_o.rdata = data_q[sc_data_i.set_idx][sc_data_i.way];
      end
      SC_FILL: begin
        resp_data_o.rdata = sc_data_i.data;   // bypass the array write.
      end
      default: begin
        resp_data_o.rdata = '0;
      end
    endcase
  end

  // tag state lives in the htu, so check it here.
  a_read_is_hit: assert property (@(posedge clk_i) disable iff (rst_i)
    sc_valid_i && sc_data_i.op == SC_READ |-> sc_data_i.hit);

endmodule

//--- rtl/bank_top.sv
`include "cache_bank_defines.svh"

module bank_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_valid_i,
  output logic                     req_allow_in_o,
  input  logic [`BANK_CH_W-1:0]    req_ch_id_i,
  input  cache_bank_pkg::bank_op_e req_opcode_i,
  input  logic [`BANK_ADDR_W-1:0]  req_addr_i,
  input  logic [`BANK_DATA_W-1:0]  req_wdata_i,
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output logic                     mem_req_we_o,
  output logic [`BANK_ADDR_W-1:0]  mem_req_addr_o,
  output logic [`BANK_DATA_W-1:0]  mem_req_wdata_o,
  input  logic                     mem_rsp_valid_i,
  input  logic [`BANK_DATA_W-1:0]  mem_rsp_data_i,
  output logic                     resp_valid_o,
  input  logic                     resp_ready_i,
  output logic [`BANK_CH_W-1:0]    resp_ch_id_o,
  output cache_bank_pkg::bank_op_e resp_opcode_o,
  output logic                     resp_hit_o,
  output logic [`BANK_DATA_W-1:0]  resp_rdata_o
);

  import cache_bank_pkg::*;

  logic       htu_valid;
  logic       htu_ready;
  htu_sc_t    htu_data;
  logic       sc_valid;
  logic       sc_ready;
  htu_sc_t    sc_data;
  logic       rsp_valid;
  logic       rsp_ready;
  bank_resp_t rsp_data;
  bank_resp_t out_data;

  // decode.
  bank_htu u_htu (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_allow_in_o  (req_allow_in_o),
    .req_ch_id_i     (req_ch_id_i),
    .req_opcode_i    (req_opcode_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .sc_valid_o      (htu_valid),
    .sc_ready_i      (htu_ready),
    .sc_data_o       (htu_data)
  );

  bank_skid_buf #(
    .payload_t(htu_sc_t)
  ) u_dec_buf (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (htu_valid),
    .ready_o (htu_ready),
    .data_i  (htu_data),
    .valid_o (sc_valid),
    .ready_i (sc_ready),
    .data_o  (sc_data)
  );

  // execute.
  bank_sram_ctrl u_sram_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .sc_valid_i   (sc_valid),
    .sc_ready_o   (sc_ready),
    .sc_data_i    (sc_data),
    .resp_valid_o (rsp_valid),
    .resp_ready_i (rsp_ready),
    .resp_data_o  (rsp_data)
  );

  // result stage.
  bank_skid_buf #(
    .payload_t(bank_resp_t)
  ) u_resp_buf (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (rsp_valid),
    .ready_o (rsp_ready),
    .data_i  (rsp_data),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i),
    .data_o  (out_data)
  );

  assign resp_ch_id_o  = out_data.ch_id;
  assign resp_opcode_o = out_data.opcode;
  assign resp_hit_o    = out_data.hit;
  assign resp_rdata_o  = out_data.rdata;

endmodule

//--- tests/bank_mem_model.sv
`include "cache_bank_defines.svh"

module bank_mem_model (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    always_ready_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  logic                    req_we_i,
  input  logic [`BANK_ADDR_W-1:0] req_addr_i,
  input  logic [`BANK_DATA_W-1:0] req_wdata_i,
  output logic                    rsp_valid_o,
  output logic [`BANK_DATA_W-1:0] rsp_data_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [`BANK_DATA_W-1:0] mem [256];
  logic [7:0]              rd_idx;
  int unsigned             wait_cnt;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = ~32'(i);  // inverse of the word address.
    end
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
  end

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_cnt <= 0;
    end else if (req_valid_i && req_ready_o) begin
      if (req_we_i) begin
        mem[req_addr_i[9:2]] <= req_wdata_i;
      end else begin
        wait_cnt <= 1 + ($urandom % 4);  // 1 to 4 cycles.
        rd_idx   <= req_addr_i[9:2];
      end
    end else if (wait_cnt != 0) begin
      wait_cnt <= wait_cnt - 1;
    end
  end

  always @(negedge clk_i) begin
    req_ready_o <= always_ready_i || ($urandom % 3 != 0);
    rsp_valid_o <= !rst_i && (wait_cnt == 1);  // one cycle pulse.
    rsp_data_o  <= mem[rd_idx];
  end

endmodule

//--- tests/bank_tb.sv
`include "cache_bank_defines.svh"

module bank_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cache_bank_pkg::*;

  typedef struct {
    bank_op_e                opcode;
    logic [`BANK_CH_W-1:0]   ch_id;
    logic [`BANK_ADDR_W-1:0] addr;
    logic [`BANK_DATA_W-1:0] wdata;
    logic                    hit;
  } req_entry_t;

  typedef struct {
    logic [`BANK_CH_W-1:0]   ch_id;
    bank_op_e                opcode;
    logic                    hit;
    logic [`BANK_DATA_W-1:0] rdata;
    int                      sent_cycle;
    bit                      timed;
  } exp_resp_t;

  localparam int NUM_REQ     = 21;
  localparam int BURST_FIRST = 13;  // four back to back hits.
  localparam int BURST_LEN   = 4;
  localparam int MAX_CYCLES  = 60 * NUM_REQ;

  logic                    clk_i = 1'b0;
  logic                    rst_i = 1'b1;
  logic                    req_valid_i;
  logic                    req_allow_in_o;
  logic [`BANK_CH_W-1:0]   req_ch_id_i;
  bank_op_e                req_opcode_i;
  logic [`BANK_ADDR_W-1:0] req_addr_i;
  logic [`BANK_DATA_W-1:0] req_wdata_i;
  logic                    mem_req_valid_o;
  logic                    mem_req_ready_i;
  logic                    mem_req_we_o;
  logic [`BANK_ADDR_W-1:0] mem_req_addr_o;
  logic [`BANK_DATA_W-1:0] mem_req_wdata_o;
  logic                    mem_rsp_valid_i;
  logic [`BANK_DATA_W-1:0] mem_rsp_data_i;
  logic                    resp_valid_o;
  logic                    resp_ready_i = 1'b0;
  logic [`BANK_CH_W-1:0]   resp_ch_id_o;
  bank_op_e                resp_opcode_o;
  logic                    resp_hit_o;
  logic [`BANK_DATA_W-1:0] resp_rdata_o;
  logic                    fast_mode = 1'b0;
  req_entry_t              req_tbl [NUM_REQ];
  exp_resp_t               exp_q [$];
  logic [`BANK_DATA_W-1:0] shadow [256];
  int                      cycle = 0;

  bank_top dut_i (.*);

  bank_mem_model u_mem (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .always_ready_i (fast_mode),
    .req_valid_i    (mem_req_valid_o),
    .req_ready_o    (mem_req_ready_i),
    .req_we_i       (mem_req_we_o),
    .req_addr_i     (mem_req_addr_o),
    .req_wdata_i    (mem_req_wdata_o),
    .rsp_valid_o    (mem_rsp_valid_i),
    .rsp_data_o     (mem_rsp_data_i)
  );

  always #4 clk_i = ~clk_i;

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, field, got, expected);
    abort_run();
  endtask

  // hit column follows two-way lru; set 1 holds A=004, B=024, C=044.
  function automatic void load_table();
    req_tbl[0]  = '{BANK_OP_READ,  2'd0, 32'h004, 32'h0,        1'b0};
    req_tbl[1]  = '{BANK_OP_READ,  2'd1, 32'h004, 32'h0,        1'b1};
    req_tbl[2]  = '{BANK_OP_READ,  2'd2, 32'h008, 32'h0,        1'b0};
    req_tbl[3]  = '{BANK_OP_READ,  2'd3, 32'h008, 32'h0,        1'b1};
    req_tbl[4]  = '{BANK_OP_WRITE, 2'd0, 32'h004, 32'h11112222, 1'b1};
    req_tbl[5]  = '{BANK_OP_READ,  2'd1, 32'h004, 32'h0,        1'b1};
    req_tbl[6]  = '{BANK_OP_WRITE, 2'd2, 32'h00c, 32'h33334444, 1'b0};  // no allocate.
    req_tbl[7]  = '{BANK_OP_READ,  2'd3, 32'h00c, 32'h0,        1'b0};
    req_tbl[8]  = '{BANK_OP_READ,  2'd0, 32'h024, 32'h0,        1'b0};
    req_tbl[9]  = '{BANK_OP_READ,  2'd1, 32'h004, 32'h0,        1'b1};
    req_tbl[10] = '{BANK_OP_READ,  2'd2, 32'h044, 32'h0,        1'b0};  // evicts B.
    req_tbl[11] = '{BANK_OP_READ,  2'd3, 32'h004, 32'h0,        1'b1};
    req_tbl[12] = '{BANK_OP_READ,  2'd0, 32'h024, 32'h0,        1'b0};
    req_tbl[13] = '{BANK_OP_READ,  2'd1, 32'h008, 32'h0,        1'b1};
    req_tbl[14] = '{BANK_OP_READ,  2'd2, 32'h00c, 32'h0,        1'b1};
    req_tbl[15] = '{BANK_OP_READ,  2'd3, 32'h024, 32'h0,        1'b1};
    req_tbl[16] = '{BANK_OP_READ,  2'd0, 32'h004, 32'h0,        1'b1};
    req_tbl[17] = '{BANK_OP_WRITE, 2'd1, 32'h024, 32'h5555aaaa, 1'b1};
    req_tbl[18] = '{BANK_OP_READ,  2'd2, 32'h024, 32'h0,        1'b1};
    req_tbl[19] = '{BANK_OP_READ,  2'd3, 32'h044, 32'h0,        1'b0};  // evicts A.
    req_tbl[20] = '{BANK_OP_READ,  2'd0, 32'h004, 32'h0,        1'b0};
  endfunction

  task automatic send_request(input req_entry_t r, input bit timed);
    exp_resp_t e;
    int        stalls;
    @(negedge clk_i);
    req_valid_i  = 1'b1;
    req_ch_id_i  = r.ch_id;
    req_opcode_i = r.opcode;
    req_addr_i   = r.addr;
    req_wdata_i  = r.wdata;
    stalls       = 0;
    @(posedge clk_i);
    while (!req_allow_in_o) begin
      stalls++;
      @(posedge clk_i);
    end
    assert (!timed || stalls == 0) else begin
      $display("a burst request was held off for %0d cycles", stalls);
      abort_run();
    end
    e.ch_id      = r.ch_id;
    e.opcode     = r.opcode;
    e.hit        = r.hit;
    e.rdata      = (r.opcode == BANK_OP_READ) ? shadow[r.addr[9:2]] : '0;
    e.sent_cycle = cycle;
    e.timed      = timed;
    exp_q.push_back(e);
    if (r.opcode == BANK_OP_WRITE) begin
      shadow[r.addr[9:2]] = r.wdata;  // write-through keeps memory current.
    end
  endtask

  task automatic drain_responses();
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    void'($urandom(32'hfb70));
    req_valid_i  = 1'b0;
    req_ch_id_i  = '0;
    req_opcode_i = BANK_OP_READ;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    load_table();
    for (int i = 0; i < 256; i++) begin
      shadow[i] = ~32'(i);
    end
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (req_allow_in_o && !resp_valid_o && !mem_req_valid_o) else begin
      $display("bank is not idle after reset");
      abort_run();
    end
    for (int i = 0; i < NUM_REQ; i++) begin
      if (i == BURST_FIRST) begin
        fast_mode = 1'b1;
        drain_responses();  // empty pipeline for exact latency.
      end
      if (i == BURST_FIRST + BURST_LEN) begin
        drain_responses();  // burst responses leave with ready still high.
        @(posedge clk_i);
        fast_mode = 1'b0;
      end
      send_request(req_tbl[i], i >= BURST_FIRST && i < BURST_FIRST + BURST_LEN);
    end
    drain_responses();
    repeat (4) @(negedge clk_i);
    $display("test passed");
    $finish;
  end

  always @(negedge clk_i) begin
    resp_ready_i <= fast_mode || ($urandom % 4 != 0);
  end

  // response checker, in request order.
  always @(posedge clk_i) begin
    exp_resp_t e;
    if (!rst_i && resp_valid_o && resp_ready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("bank returned a response with no request outstanding");
        abort_run();
      end
      e = exp_q.pop_front();
      assert (resp_ch_id_o == e.ch_id)
        else report_mismatch("channel id", resp_ch_id_o, e.ch_id);
      assert (resp_opcode_o == e.opcode)
        else report_mismatch("opcode", resp_opcode_o, e.opcode);
      assert (resp_hit_o == e.hit)
        else report_mismatch("hit flag", resp_hit_o, e.hit);
      assert (resp_rdata_o == e.rdata)
        else report_mismatch("read data", resp_rdata_o, e.rdata);
      assert (!e.timed || cycle - e.sent_cycle == 2)
        else report_mismatch("hit latency", cycle - e.sent_cycle, 2);
    end
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout, the bank stopped making progress after %0d cycles", cycle);
      abort_run();
    end
  end

endmodule

//--- cache_bank.f
+incdir+rtl
rtl/cache_bank_pkg.sv
rtl/bank_skid_buf.sv
rtl/bank_htu.sv
rtl/bank_sram_ctrl.sv
rtl/bank_top.sv
tests/bank_mem_model.sv
tests/bank_tb.sv
